/* Makefile */
VERILATOR ?= verilator
TOP       ?= execute_stage_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "=== PASS ===" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* hw/alu_core.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ex_settings.svh"

module alu_core
    import ex_pkg::*;
(
    input  wire opcode_t opcode,
    input  wire xlen_t   op_a,
    input  wire xlen_t   op_b,
    input  wire xlen_t   imm,
    input  wire xlen_t   pcplus1,
    output xlen_t        alu_result,
    output logic         update_rd,
    output logic         mm_load
);

    xlen_t                  src_b;
    xlen_t                  addr;
    logic [`EX_SHAMT_W-1:0] shamt;

    // Immediate forms take imm as the second operand
    always_comb
    begin
        case (opcode)
            ADDI, SLTI, SLTIU, XORI, ORI, ANDI, SLLI, SRLI, SRAI:
                src_b = imm;
            default:
                src_b = op_b;
        endcase
    end

    assign shamt = src_b[`EX_SHAMT_W-1:0];
    assign addr  = op_a + imm;

    always_comb
    begin
        alu_result = '0;
        update_rd  = 1'b1;
        mm_load    = 1'b0;
        case (opcode)
            ADD, ADDI:   alu_result = op_a + src_b;
            SUB:         alu_result = op_a - src_b;
            SLL, SLLI:   alu_result = op_a << shamt;
            SLT, SLTI:   alu_result = xlen_t'($signed(op_a) < $signed(src_b));
            SLTU, SLTIU: alu_result = xlen_t'(op_a < src_b);
            XOR, XORI:   alu_result = op_a ^ src_b;
            SRL, SRLI:   alu_result = op_a >> shamt;
            SRA, SRAI:   alu_result = xlen_t'($signed(op_a) >>> shamt);
            OR, ORI:     alu_result = op_a | src_b;
            AND, ANDI:   alu_result = op_a & src_b;
            LUI:         alu_result = imm;
            AUIPC:       alu_result = pcplus1 - xlen_t'(`EX_PC_STEP) + imm;
            // Link address
            JAL, JALR:   alu_result = pcplus1;
            LB, LH, LW, LD, LBU, LHU, LWU:
            begin
                alu_result = addr;
                update_rd  = 1'b0;
                mm_load    = 1'b1;
            end
            SB, SH, SW, SD:
            begin
                alu_result = addr;
                update_rd  = 1'b0;
            end
            // Bubble and conditional branches write nothing
            default:
            begin
                update_rd = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* hw/branch_unit.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ex_settings.svh"

module branch_unit
    import ex_pkg::*;
(
    input  wire opcode_t opcode,
    input  wire xlen_t   op_a,
    input  wire xlen_t   op_b,
    input  wire xlen_t   imm,
    input  wire xlen_t   pcplus1,
    output logic         taken,
    output xlen_t        target_pc
);

    xlen_t jalr_sum;
    xlen_t pc_rel;

    assign jalr_sum = op_a + imm;
    assign pc_rel   = pcplus1 - xlen_t'(`EX_PC_STEP) + imm;

    always_comb
    begin
        case (opcode)
            BEQ:       taken = (op_a == op_b);
            BNE:       taken = (op_a != op_b);
            BLT:       taken = ($signed(op_a) < $signed(op_b));
            BGE:       taken = ($signed(op_a) >= $signed(op_b));
            BLTU:      taken = (op_a < op_b);
            BGEU:      taken = (op_a >= op_b);
            JAL, JALR: taken = 1'b1;
            default:   taken = 1'b0;
        endcase
    end

    // jalr drops bit 0 of the computed address
    always_comb
    begin
        if (!taken)
            target_pc = pcplus1;
        else if (opcode == JALR)
            target_pc = {jalr_sum[`EX_XLEN-1:1], 1'b0};
        else
            target_pc = pc_rel;
    end

endmodule

`default_nettype wire

/* hw/ex_pkg.sv */
`default_nettype none

`include "ex_settings.svh"

package ex_pkg;

    typedef logic [`EX_XLEN-1:0] xlen_t;
    typedef logic [`EX_REGNO_W-1:0] regno_t;

    // NOP doubles as the bubble, so it must stay at zero
    typedef enum logic [5:0] {
        NOP = 6'd0,
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND,
        ADDI, SLTI, SLTIU, XORI, ORI, ANDI, SLLI, SRLI, SRAI,
        LUI, AUIPC,
        LB, LH, LW, LD, LBU, LHU, LWU,
        SB, SH, SW, SD,
        BEQ, BNE, BLT, BGE, BLTU, BGEU,
        JAL, JALR
    } opcode_t;

    typedef enum logic {
        RUN,
        LOAD_WAIT
    } stall_state_t;

    typedef struct packed {
        opcode_t opcode;
        regno_t  rd_regno;
        regno_t  rs1_regno;
        regno_t  rs2_regno;
        xlen_t   rs1_value;
        xlen_t   rs2_value;
        xlen_t   imm;
        xlen_t   pcplus1;
    } ex_issue_t;

    // Destination of an instruction further down the pipe
    typedef struct packed {
        regno_t rd_regno;
        logic   update_rd;
        logic   mm_load;
    } fwd_tag_t;

    typedef struct packed {
        xlen_t   alu_result;
        xlen_t   rs2_value;
        regno_t  rd_regno;
        opcode_t opcode;
        xlen_t   target_pc;
        logic    update_rd;
        logic    branch_taken;
        logic    mm_load;
    } ex_result_t;

endpackage

`default_nettype wire

/* hw/execute_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module execute_stage
    import ex_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      reset,
    input  wire logic      enable,
    input  wire ex_issue_t issue,
    input  wire fwd_tag_t  alu_tag,
    input  wire fwd_tag_t  mm_tag,
    input  wire fwd_tag_t  wb_tag,
    input  wire xlen_t     alu_fwd_data,
    input  wire xlen_t     mm_mdata,
    input  wire xlen_t     mm_alu_result,
    input  wire xlen_t     wb_data,
    input  wire logic      branch_flush,
    input  wire logic      syscall_flush,
    output ex_result_t     result,
    output logic           ready
);

    xlen_t        rs1_value;
    xlen_t        rs2_value;
    logic         rs1_hazard;
    logic         rs2_hazard;
    stall_state_t state;
    xlen_t        alu_result;
    logic         update_rd;
    logic         mm_load;
    logic         taken;
    xlen_t        target_pc;
    ex_result_t   next_result;

    operand_bypass rs1_bypass (
        .regno         (issue.rs1_regno),
        .reg_value     (issue.rs1_value),
        .alu_tag       (alu_tag),
        .mm_tag        (mm_tag),
        .wb_tag        (wb_tag),
        .alu_fwd_data  (alu_fwd_data),
        .mm_mdata      (mm_mdata),
        .mm_alu_result (mm_alu_result),
        .wb_data       (wb_data),
        .state         (state),
        .value         (rs1_value),
        .load_hazard   (rs1_hazard)
    );

    operand_bypass rs2_bypass (
        .regno         (issue.rs2_regno),
        .reg_value     (issue.rs2_value),
        .alu_tag       (alu_tag),
        .mm_tag        (mm_tag),
        .wb_tag        (wb_tag),
        .alu_fwd_data  (alu_fwd_data),
        .mm_mdata      (mm_mdata),
        .mm_alu_result (mm_alu_result),
        .wb_data       (wb_data),
        .state         (state),
        .value         (rs2_value),
        .load_hazard   (rs2_hazard)
    );

    stall_fsm u_stall_fsm (
        .clk           (clk),
        .reset         (reset),
        .enable        (enable),
        .syscall_flush (syscall_flush),
        .hazard        (rs1_hazard | rs2_hazard),
        .state         (state),
        .ready         (ready)
    );

    alu_core u_alu_core (
        .opcode     (issue.opcode),
        .op_a       (rs1_value),
        .op_b       (rs2_value),
        .imm        (issue.imm),
        .pcplus1    (issue.pcplus1),
        .alu_result (alu_result),
        .update_rd  (update_rd),
        .mm_load    (mm_load)
    );

    branch_unit u_branch_unit (
        .opcode    (issue.opcode),
        .op_a      (rs1_value),
        .op_b      (rs2_value),
        .imm       (issue.imm),
        .pcplus1   (issue.pcplus1),
        .taken     (taken),
        .target_pc (target_pc)
    );

    always_comb
    begin
        next_result.alu_result   = alu_result;
        // Store data travels with the forwarded value
        next_result.rs2_value    = rs2_value;
        next_result.rd_regno     = issue.rd_regno;
        next_result.opcode       = issue.opcode;
        next_result.target_pc    = target_pc;
        next_result.update_rd    = update_rd;
        next_result.branch_taken = taken;
        next_result.mm_load      = mm_load;
    end

    // Stall cycles and branch flushes both leave a bubble behind
    always_ff @(posedge clk)
    begin
        if (reset || syscall_flush)
        begin
            result <= '0;
        end
        else if (enable)
        begin
            if (ready && !branch_flush)
                result <= next_result;
            else
                result <= '0;
        end
    end

endmodule

`default_nettype wire

/* hw/operand_bypass.sv */
`timescale 1ns/10ps
`default_nettype none

module operand_bypass
    import ex_pkg::*;
(
    input  wire regno_t       regno,
    input  wire xlen_t        reg_value,
    input  wire fwd_tag_t     alu_tag,
    input  wire fwd_tag_t     mm_tag,
    input  wire fwd_tag_t     wb_tag,
    input  wire xlen_t        alu_fwd_data,
    input  wire xlen_t        mm_mdata,
    input  wire xlen_t        mm_alu_result,
    input  wire xlen_t        wb_data,
    input  wire stall_state_t state,
    output xlen_t             value,
    output logic              load_hazard
);

    logic alu_hit;
    logic mm_hit;
    logic wb_hit;

    assign alu_hit = (regno == alu_tag.rd_regno);
    assign mm_hit  = (regno == mm_tag.rd_regno);
    assign wb_hit  = (regno == wb_tag.rd_regno);

    // Youngest producer wins: ALU stage, then memory, then write-back
    always_comb
    begin
        value       = reg_value;
        load_hazard = 1'b0;
        if (regno == '0)
        begin
            value = '0;
        end
        else if (alu_hit && alu_tag.mm_load)
        begin
            // Load data only exists once the load reaches memory
            if (state == LOAD_WAIT)
                value = mm_mdata;
            else
                load_hazard = 1'b1;
        end
        else if (alu_hit && alu_tag.update_rd)
        begin
            value = alu_fwd_data;
        end
        else if (mm_hit)
        begin
            if (mm_tag.mm_load)
                value = mm_mdata;
            else if (mm_tag.update_rd)
                value = mm_alu_result;
        end
        else if (wb_hit && wb_tag.update_rd)
        begin
            value = wb_data;
        end
    end

endmodule

`default_nettype wire

/* hw/stall_fsm.sv */
`timescale 1ns/10ps
`default_nettype none

module stall_fsm
    import ex_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    reset,
    input  wire logic    enable,
    input  wire logic    syscall_flush,
    input  wire logic    hazard,
    output stall_state_t state,
    output logic         ready
);

    stall_state_t next_state;

    // In LOAD_WAIT the load data is on mm_mdata, so no further stall
    assign ready = !((state == RUN) && hazard);

    always_comb
    begin
        next_state = state;
        case (state)
            RUN:
            begin
                if (enable && hazard)
                    next_state = LOAD_WAIT;
            end
            LOAD_WAIT:
            begin
                if (enable && ready)
                    next_state = RUN;
            end
            default:
                next_state = RUN;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset || syscall_flush)
            state <= RUN;
        else
            state <= next_state;
    end

endmodule

`default_nettype wire

/* include/ex_settings.svh */
`ifndef EX_SETTINGS_SVH
`define EX_SETTINGS_SVH

// Register width
`define EX_XLEN 64

// Register-number width
`define EX_REGNO_W 5

// Shift amount for 64-bit shifts
`define EX_SHAMT_W 6

// Distance from an instruction's address to pcplus1
`define EX_PC_STEP 4

`endif

/* project.f */
+incdir+include
hw/ex_pkg.sv
hw/operand_bypass.sv
hw/alu_core.sv
hw/branch_unit.sv
hw/stall_fsm.sv
hw/execute_stage.sv
verif/execute_stage_chk.sv
verif/execute_stage_tb.sv

/* verif/execute_golden.txt */
# name op rd rs1 rs2 rs1_val rs2_val imm pcplus1 alu_tag mm_tag wb_tag alu_fwd mm_mdata mm_alu wb en bflush sflush
#   then expected: ready alu_result rs2_value rd opcode target_pc update_rd taken mm_load (all hex)
add 1 5 1 2 10 3 0 1004 0 0 0 0 0 0 0 1 0 0 1 13 3 5 1 1004 1 0 0
sub 2 5 1 2 10 3 0 1004 0 0 0 0 0 0 0 1 0 0 1 d 3 5 2 1004 1 0 0
sll 3 5 1 2 1 44 0 1004 0 0 0 0 0 0 0 1 0 0 1 10 44 5 3 1004 1 0 0
slt 4 5 1 2 ffffffffffffffff 1 0 1004 0 0 0 0 0 0 0 1 0 0 1 1 1 5 4 1004 1 0 0
sltu 5 5 1 2 ffffffffffffffff 1 0 1004 0 0 0 0 0 0 0 1 0 0 1 0 1 5 5 1004 1 0 0
xor 6 5 1 2 f0 ff 0 1004 0 0 0 0 0 0 0 1 0 0 1 f ff 5 6 1004 1 0 0
srl 7 5 1 2 8000000000000000 3f 0 1004 0 0 0 0 0 0 0 1 0 0 1 1 3f 5 7 1004 1 0 0
sra 8 5 1 2 8000000000000000 3f 0 1004 0 0 0 0 0 0 0 1 0 0 1 ffffffffffffffff 3f 5 8 1004 1 0 0
or 9 5 1 2 f0 f 0 1004 0 0 0 0 0 0 0 1 0 0 1 ff f 5 9 1004 1 0 0
and a 5 1 2 f0 3c 0 1004 0 0 0 0 0 0 0 1 0 0 1 30 3c 5 a 1004 1 0 0
addi b 5 1 0 10 99 fffffffffffffffe 1004 0 0 0 0 0 0 0 1 0 0 1 e 0 5 b 1004 1 0 0
slti c 5 1 0 5 99 7 1004 0 0 0 0 0 0 0 1 0 0 1 1 0 5 c 1004 1 0 0
sltiu d 5 1 0 5 99 ffffffffffffffff 1004 0 0 0 0 0 0 0 1 0 0 1 1 0 5 d 1004 1 0 0
xori e 5 1 0 ff 99 f 1004 0 0 0 0 0 0 0 1 0 0 1 f0 0 5 e 1004 1 0 0
ori f 5 1 0 f0 99 5 1004 0 0 0 0 0 0 0 1 0 0 1 f5 0 5 f 1004 1 0 0
andi 10 5 1 0 ff 99 3c 1004 0 0 0 0 0 0 0 1 0 0 1 3c 0 5 10 1004 1 0 0
slli 11 5 1 0 3 99 2 1004 0 0 0 0 0 0 0 1 0 0 1 c 0 5 11 1004 1 0 0
srli 12 5 1 0 80 99 4 1004 0 0 0 0 0 0 0 1 0 0 1 8 0 5 12 1004 1 0 0
srai 13 5 1 0 fffffffffffffff0 99 4 1004 0 0 0 0 0 0 0 1 0 0 1 ffffffffffffffff 0 5 13 1004 1 0 0
lui 14 5 0 0 0 0 12345000 1004 0 0 0 0 0 0 0 1 0 0 1 12345000 0 5 14 1004 1 0 0
auipc 15 5 0 0 0 0 100 1004 0 0 0 0 0 0 0 1 0 0 1 1100 0 5 15 1004 1 0 0
fwd_alu 1 5 1 2 1 2 0 1004 6 6 6 100 0 200 300 1 0 0 1 102 2 5 1 1004 1 0 0
fwd_mm 1 5 1 2 1 2 0 1004 0 6 6 100 0 200 300 1 0 0 1 202 2 5 1 1004 1 0 0
fwd_mm_load 1 5 1 2 1 2 0 1004 0 5 6 100 400 200 300 1 0 0 1 402 2 5 1 1004 1 0 0
fwd_wb 1 5 1 2 1 2 0 1004 0 0 6 100 400 200 300 1 0 0 1 302 2 5 1 1004 1 0 0
x0_zero 1 5 0 2 55 2 0 1004 2 0 0 100 0 0 0 1 0 0 1 2 2 5 1 1004 1 0 0
load_stall 1 5 1 2 1 2 0 1004 5 0 0 0 500 0 0 1 0 0 0 0 0 0 0 0 0 0 0
load_resume 1 5 1 2 1 2 0 1004 5 0 0 0 500 0 0 1 0 0 1 502 2 5 1 1004 1 0 0
ld 19 5 1 0 1000 0 8 1004 0 0 0 0 0 0 0 1 0 0 1 1008 0 5 19 1004 0 0 1
sd 20 0 1 2 1000 abcd 10 1004 0 0 0 0 0 0 0 1 0 0 1 1010 abcd 0 20 1004 0 0 0
beq 21 0 1 2 7 7 40 1004 0 0 0 0 0 0 0 1 0 0 1 0 7 0 21 1040 0 1 0
bne 22 0 1 2 7 7 40 1004 0 0 0 0 0 0 0 1 0 0 1 0 7 0 22 1004 0 0 0
blt 23 0 1 2 ffffffffffffffff 1 20 1004 0 0 0 0 0 0 0 1 0 0 1 0 1 0 23 1020 0 1 0
bge 24 0 1 2 ffffffffffffffff 1 20 1004 0 0 0 0 0 0 0 1 0 0 1 0 1 0 24 1004 0 0 0
bltu 25 0 1 2 ffffffffffffffff 1 20 1004 0 0 0 0 0 0 0 1 0 0 1 0 1 0 25 1004 0 0 0
bgeu 26 0 1 2 ffffffffffffffff 1 20 1004 0 0 0 0 0 0 0 1 0 0 1 0 1 0 26 1020 0 1 0
jal 27 1 0 0 0 0 200 1004 0 0 0 0 0 0 0 1 0 0 1 1004 0 1 27 1200 1 1 0
jalr 28 1 1 0 2001 0 4 1004 0 0 0 0 0 0 0 1 0 0 1 1004 0 1 28 2004 1 1 0
branch_flush 1 5 1 2 1 2 0 1004 0 0 0 0 0 0 0 1 1 0 1 0 0 0 0 0 0 0 0
refill 1 5 1 2 1 2 0 1004 0 0 0 0 0 0 0 1 0 0 1 3 2 5 1 1004 1 0 0
hold 1 5 1 2 7 7 0 1004 0 0 0 0 0 0 0 0 0 0 1 3 2 5 1 1004 1 0 0
syscall_flush 1 5 1 2 1 2 0 1004 0 0 0 0 0 0 0 1 0 1 1 0 0 0 0 0 0 0 0

/* verif/execute_stage_chk.sv */
`timescale 1ns/10ps
`default_nettype none

module execute_stage_chk
    import ex_pkg::*;
(
    input wire logic       clk,
    input wire logic       reset,
    input wire logic       enable,
    input wire logic       syscall_flush,
    input wire logic       ready,
    input wire ex_result_t result
);

    int fail_count = 0;

    clear_after_flush: assert property (@(posedge clk)
        (reset || syscall_flush) |=> (result == '0))
    else
    begin
        fail_count = fail_count + 1;
        $error("result not cleared after reset or syscall flush");
    end

    // A load-use stall lasts one enabled cycle only
    single_stall: assert property (@(posedge clk) disable iff (reset)
        (enable && !ready) |=> (!enable || ready))
    else
    begin
        fail_count = fail_count + 1;
        $error("ready low on two enabled cycles in a row");
    end

    taken_not_load: assert property (@(posedge clk) disable iff (reset)
        !(result.branch_taken && result.mm_load))
    else
    begin
        fail_count = fail_count + 1;
        $error("branch_taken and mm_load both set");
    end

endmodule

bind execute_stage execute_stage_chk u_chk (
    .clk           (clk),
    .reset         (reset),
    .enable        (enable),
    .syscall_flush (syscall_flush),
    .ready         (ready),
    .result        (result)
);

`default_nettype wire

/* verif/execute_stage_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module execute_stage_tb
    import ex_pkg::*;
;

    logic       clk;
    logic       reset;
    logic       enable;
    ex_issue_t  issue;
    fwd_tag_t   alu_tag;
    fwd_tag_t   mm_tag;
    fwd_tag_t   wb_tag;
    xlen_t      alu_fwd_data;
    xlen_t      mm_mdata;
    xlen_t      mm_alu_result;
    xlen_t      wb_data;
    logic       branch_flush;
    logic       syscall_flush;
    ex_result_t result;
    logic       ready;

    string      lines[$];
    int         error_count;
    int         cycle_count;
    int         cycle_limit;

    execute_stage UUT (
        .clk           (clk),
        .reset         (reset),
        .enable        (enable),
        .issue         (issue),
        .alu_tag       (alu_tag),
        .mm_tag        (mm_tag),
        .wb_tag        (wb_tag),
        .alu_fwd_data  (alu_fwd_data),
        .mm_mdata      (mm_mdata),
        .mm_alu_result (mm_alu_result),
        .wb_data       (wb_data),
        .branch_flush  (branch_flush),
        .syscall_flush (syscall_flush),
        .result        (result),
        .ready         (ready)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Run limit grows with the vector count once the file is read
    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > cycle_limit)
        begin
            $display("Timeout: run exceeded %0d cycles", cycle_limit);
            $display("=== FAIL ===");
            $fatal(1, "simulation did not finish in time");
        end
    end

    task automatic compare(input string name, input string field,
                           input logic [63:0] expected, input logic [63:0] actual);
        if (expected !== actual)
        begin
            error_count++;
            $display("Error: %s %s expected %h actual %h", name, field, expected, actual);
            $display("=== FAIL ===");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic load_vectors();
        int    fd;
        string line;
        fd = $fopen("verif/execute_golden.txt", "r");
        if (fd == 0)
        begin
            $display("Could not open the golden vector file");
            $display("=== FAIL ===");
            $fatal(1, "missing vector file");
        end
        while (!$feof(fd))
        begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line.getc(0) != "#")
                lines.push_back(line);
        end
        $fclose(fd);
    endtask

    task automatic apply_vector(input string line);
        string       name;
        logic [63:0] f[27];
        int          n;
        n = $sscanf(line,
            "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
            name, f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
            f[9], f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17],
            f[18], f[19], f[20], f[21], f[22], f[23], f[24], f[25], f[26]);
        if (n != 28)
        begin
            $display("Malformed vector line: %s", line);
            $display("=== FAIL ===");
            $fatal(1, "bad vector file");
        end
        issue.opcode    = opcode_t'(f[0][5:0]);
        issue.rd_regno  = f[1][4:0];
        issue.rs1_regno = f[2][4:0];
        issue.rs2_regno = f[3][4:0];
        issue.rs1_value = f[4];
        issue.rs2_value = f[5];
        issue.imm       = f[6];
        issue.pcplus1   = f[7];
        alu_tag         = f[8][6:0];
        mm_tag          = f[9][6:0];
        wb_tag          = f[10][6:0];
        alu_fwd_data    = f[11];
        mm_mdata        = f[12];
        mm_alu_result   = f[13];
        wb_data         = f[14];
        enable          = f[15][0];
        branch_flush    = f[16][0];
        syscall_flush   = f[17][0];
        @(negedge clk);
        compare(name, "ready", f[18], 64'(ready));
        @(posedge clk);
        #1;
        compare(name, "alu_result", f[19], result.alu_result);
        compare(name, "rs2_value", f[20], result.rs2_value);
        compare(name, "rd_regno", f[21], 64'(result.rd_regno));
        compare(name, "opcode", f[22], 64'(result.opcode));
        compare(name, "target_pc", f[23], result.target_pc);
        compare(name, "update_rd", f[24], 64'(result.update_rd));
        compare(name, "branch_taken", f[25], 64'(result.branch_taken));
        compare(name, "mm_load", f[26], 64'(result.mm_load));
    endtask

    initial
    begin
        reset         = 1'b1;
        enable        = 1'b0;
        issue         = '0;
        alu_tag       = '0;
        mm_tag        = '0;
        wb_tag        = '0;
        alu_fwd_data  = '0;
        mm_mdata      = '0;
        mm_alu_result = '0;
        wb_data       = '0;
        branch_flush  = 1'b0;
        syscall_flush = 1'b0;
        error_count   = 0;
        cycle_count   = 0;
        cycle_limit   = 36;
        load_vectors();
        cycle_limit = 16 + 2 * lines.size() + 20;
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;
        compare("reset", "result", 64'd0, 64'(|result));
        foreach (lines[i])
            apply_vector(lines[i]);
        if (error_count == 0 && UUT.u_chk.fail_count == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire
